// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_syscfg
FILELIST  ?= sim.f
BUILD     ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)

// ==== bench/syscfg_testdata.txt ====
// columns: op addr data strb expect resp, all hex, addr in bytes
// op 1 write, 2 read, 3 wait idle (expect is tgt_rst), 4 set irq (expect is core_irq)
// op 5 boot address (addr is core index), op 0 ends the list
3 1008 0 0 a 0
2 0400 0 0 0 0
2 1000 0 0 0 0
2 040c 0 0 2 0
2 1014 0 0 2 0
// memory 1 resume, pause, stop, resume
1 0414 1 f 0 0
3 0414 0 0 8 0
2 040c 0 0 0 0
1 0414 2 f 0 0
3 0414 0 0 8 0
2 040c 0 0 1 0
1 0414 3 f 0 0
3 0414 0 0 a 0
2 040c 0 0 3 0
1 0414 1 f 0 0
3 0414 0 0 8 0
2 040c 0 0 0 0
// core 1 reset, second command while busy
1 101c 4 f 0 0
1 101c 1 f 0 2
3 101c 0 0 0 0
2 1014 0 0 0 0
// boot address under partial strobe
2 100c 0 0 1000 0
5 0 0 0 1000 0
1 100c aabbccdd 5 0 0
2 100c 0 0 00bb10dd 0
5 0 0 0 00bb10dd 0
5 1 0 0 1000 0
// interrupt masking
1 1010 5 f 0 0
1 1024 a f 0 0
4 0 3 0 3 0
4 0 4 0 1 0
4 0 8 0 2 0
4 0 0 0 0 0
// error cases
1 1000 1 f 0 2
1 0410 1 f 0 2
1 0418 1 f 0 2
1 1028 1 f 0 2
1 0040 1 f 0 2
0 0 0 0 0 0

// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 2;

    // free running clock, first edge rises
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_syscfg.sv ====
`default_nettype none

module tb_syscfg import syscfg_bus_pkg::*; import syscfg_ctrl_pkg::*; ();

    // one data file record is six hex words
    localparam int FIELDS       = 6;
    localparam int MAX_RECORDS  = 64;
    localparam int WATCH_CYCLES = 200;

    localparam data_t OP_END   = 32'd0;
    localparam data_t OP_WRITE = 32'd1;
    localparam data_t OP_READ  = 32'd2;
    localparam data_t OP_WAIT  = 32'd3;
    localparam data_t OP_IRQ   = 32'd4;
    localparam data_t OP_BOOT  = 32'd5;

    logic                   clk;
    logic                   rst_n;
    addr_t                  awaddr;
    logic                   awvalid;
    logic                   awready;
    data_t                  wdata;
    strb_t                  wstrb;
    logic                   wvalid;
    logic                   wready;
    resp_t                  bresp;
    logic                   bvalid;
    logic                   bready;
    addr_t                  araddr;
    logic                   arvalid;
    logic                   arready;
    data_t                  rdata;
    resp_t                  rresp;
    logic                   rvalid;
    logic                   rready;
    logic [NUM_TARGETS-1:0] tgt_rst;
    logic [NUM_TARGETS-1:0] tgt_pause_req;
    logic [NUM_TARGETS-1:0] tgt_pause_ack = '0;
    logic [NUM_IRQS-1:0]    periph_irq;
    data_t                  core_boot_addr [NUM_CORES];
    logic [NUM_CORES-1:0]   core_irq;

    data_t                  testdata [MAX_RECORDS*FIELDS];
    int                     num_records;
    int unsigned            ack_cnt   [NUM_TARGETS];
    int unsigned            ack_delay [NUM_TARGETS];

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    syscfg_top i_syscfg_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .tgt_rst        (tgt_rst),
        .tgt_pause_req  (tgt_pause_req),
        .tgt_pause_ack  (tgt_pause_ack),
        .periph_irq     (periph_irq),
        .core_boot_addr (core_boot_addr),
        .core_irq       (core_irq)
    );

    // target models, ack follows req after 1 to 4 cycles
    always @(negedge clk) begin
        for (int t = 0; t < NUM_TARGETS; t++) begin
            if (tgt_pause_req[t] != tgt_pause_ack[t]) begin
                // new delay at the start of each change
                if (ack_cnt[t] == 0) begin
                    ack_delay[t] = 1 + ($urandom % 4);
                end
                ack_cnt[t] = ack_cnt[t] + 1;
                if (ack_cnt[t] >= ack_delay[t]) begin
                    tgt_pause_ack[t] <= tgt_pause_req[t];
                    ack_cnt[t] = 0;
                end
            end
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // per-target vectors, tgt_rst and tgt_pause_req
    task automatic check_tgt_vec(input string name, input logic [NUM_TARGETS-1:0] got,
                                 input logic [NUM_TARGETS-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // called and returns on a falling edge
    task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb,
                             output resp_t resp);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // ready seen here means the handshake is on the next rising edge
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t addr, output data_t data, output resp_t resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // poll a command register until the sequencer is idle
    task automatic wait_idle(input addr_t addr);
        data_t rd;
        resp_t rs;
        rd = '1;
        while (rd != '0) begin
            axi_read(addr, rd, rs);
            check_resp("rresp", rs, RESP_OKAY);
        end
    endtask

    // watchdog scaled by the number of records
    initial begin
        wait (num_records > 0);
        repeat (num_records * WATCH_CYCLES) @(posedge clk);
        $display("timeout, the DUT stopped answering before all records were run");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        data_t op;
        addr_t addr;
        data_t data;
        strb_t strb;
        data_t expv;
        resp_t exp_resp;
        data_t rd;
        resp_t rs;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        periph_irq = '0;
        void'($urandom(6));
        $readmemh("bench/syscfg_testdata.txt", testdata);
        // records end at the first op of zero
        num_records = 0;
        while (num_records < MAX_RECORDS && testdata[num_records*FIELDS] != OP_END) begin
            num_records++;
        end
        wait (rst_n === 1'b1);
        // every target held, no pause request, no interrupt right after reset
        check_tgt_vec("tgt_rst", tgt_rst, {NUM_TARGETS{1'b1}});
        check_tgt_vec("tgt_pause_req", tgt_pause_req, '0);
        check_data("core_irq", data_t'(core_irq), '0);
        @(negedge clk);
        for (int r = 0; r < num_records; r++) begin
            op       = testdata[r*FIELDS];
            addr     = addr_t'(testdata[r*FIELDS+1]);
            data     = testdata[r*FIELDS+2];
            strb     = strb_t'(testdata[r*FIELDS+3]);
            expv     = testdata[r*FIELDS+4];
            exp_resp = resp_t'(testdata[r*FIELDS+5]);
            case (op)
                OP_WRITE: begin
                    axi_write(addr, data, strb, rs);
                    check_resp("bresp", rs, exp_resp);
                end
                OP_READ: begin
                    axi_read(addr, rd, rs);
                    check_data("rdata", rd, expv);
                    check_resp("rresp", rs, exp_resp);
                end
                OP_WAIT: begin
                    wait_idle(addr);
                    check_tgt_vec("tgt_rst", tgt_rst, expv[NUM_TARGETS-1:0]);
                end
                OP_IRQ: begin
                    periph_irq = data[NUM_IRQS-1:0];
                    @(negedge clk);
                    check_data("core_irq", data_t'(core_irq), expv);
                end
                OP_BOOT: begin
                    // addr field holds the core index
                    if (addr >= addr_t'(NUM_CORES)) begin
                        $display("record %0d names core %0d, which does not exist", r, addr);
                        $display("test failed");
                        $fatal(1, "bad data file");
                    end else begin
                        for (int c = 0; c < NUM_CORES; c++) begin
                            if (addr == addr_t'(c)) begin
                                check_data($sformatf("core_boot_addr[%0d]", c),
                                           core_boot_addr[c], expv);
                            end
                        end
                    end
                end
                default: begin
                    $display("record %0d holds an unknown operation code %h", r, op);
                    $display("test failed");
                    $fatal(1, "bad data file");
                end
            endcase
        end
        if (num_records > 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("no records ran, the data file is empty or unreadable");
            $display("test failed");
            $fatal(1, "nothing checked");
        end
    end

endmodule

`default_nettype wire

// ==== logic/axil_slave_port.sv ====
`default_nettype none

module axil_slave_port import syscfg_bus_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,

    input  wire addr_t    awaddr,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire data_t    wdata,
    input  wire strb_t    wstrb,
    input  wire logic     wvalid,
    output logic          wready,
    output resp_t         bresp,
    output logic          bvalid,
    input  wire logic     bready,
    input  wire addr_t    araddr,
    input  wire logic     arvalid,
    output logic          arready,
    output data_t         rdata,
    output resp_t         rresp,
    output logic          rvalid,
    input  wire logic     rready,

    input  wire logic     ready,
    output reg_req_t      req,
    input  wire reg_rsp_t rsp
);

    // one access in flight from address to response
    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_WAIT, ST_RESP} state_t;

    state_t state;
    logic   is_read;
    logic   aw_hs;
    logic   ar_hs;

    // readies and valids come straight from the state
    assign arready = (state == ST_ADDR) && is_read;
    assign awready = (state == ST_ADDR) && !is_read;
    assign wready  = (state == ST_ADDR) && !is_read;
    assign rvalid  = (state == ST_RESP) && is_read;
    assign bvalid  = (state == ST_RESP) && !is_read;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready && wvalid && wready;

    // byte address to word index, single-cycle launch
    always_comb begin
        req.valid = ar_hs || aw_hs;
        req.write = !is_read;
        req.index = is_read ? (araddr >> $clog2(STRB_WIDTH)) : (awaddr >> $clog2(STRB_WIDTH));
        req.wdata = wdata;
        req.strb  = is_read ? '0 : wstrb;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            is_read <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    // read wins over a write in the same cycle
                    if (ready && arvalid) begin
                        is_read <= 1'b1;
                        state   <= ST_ADDR;
                    end else if (ready && awvalid && wvalid) begin
                        is_read <= 1'b0;
                        state   <= ST_ADDR;
                    end
                end
                ST_ADDR: state <= (ar_hs || aw_hs) ? ST_WAIT : ST_IDLE;
                // register file answers here
                ST_WAIT: state <= ST_RESP;
                ST_RESP: begin
                    if (is_read ? rready : bready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // response payload, held until taken
    always_ff @(posedge clk) begin
        if (state == ST_WAIT) begin
            if (is_read) begin
                rdata <= rsp.rdata;
                rresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
            end else begin
                bresp <= rsp.err ? RESP_SLVERR : RESP_OKAY;
            end
        end
    end

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== logic/syscfg_bus_pkg.sv ====
`default_nettype none

package syscfg_bus_pkg;

    // axi4-lite bus geometry
    localparam int ADDR_WIDTH = 14;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    // response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // register map in 32-bit words
    localparam addr_t MEM_BASE    = addr_t'(12'h100);
    localparam addr_t MEM_STRIDE  = addr_t'(3);
    localparam addr_t CORE_BASE   = addr_t'(12'h400);
    localparam addr_t CORE_STRIDE = addr_t'(5);

    // slot offsets inside one block
    localparam addr_t REG_STATUS    = addr_t'(0);
    localparam addr_t REG_COMMAND   = addr_t'(2);
    localparam addr_t REG_BOOT_ADDR = addr_t'(3);
    localparam addr_t REG_IRQ_EN    = addr_t'(4);

    localparam data_t BOOT_ADDR_RESET = 32'h0000_1000;

    // one register access, index counts words
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t index;
        data_t wdata;
        strb_t strb;
    } reg_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } reg_rsp_t;

endpackage

`default_nettype wire

// ==== logic/syscfg_ctrl_pkg.sv ====
`default_nettype none

package syscfg_ctrl_pkg;

    // managed targets, memories come first
    localparam int NUM_MEMS    = 2;
    localparam int NUM_CORES   = 2;
    localparam int NUM_TARGETS = NUM_MEMS + NUM_CORES;

    // peripheral interrupt lines per core
    localparam int NUM_IRQS = 4;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_RESUME = 3'd1,
        CMD_PAUSE  = 3'd2,
        CMD_STOP   = 3'd3,
        CMD_RESET  = 3'd4
    } cmd_t;

    // one-cycle command pulse to a sequencer
    typedef struct packed {
        logic valid;
        cmd_t cmd;
    } tgt_cmd_t;

    typedef struct packed {
        logic paused;
        logic stopped;
        cmd_t cmd;
    } tgt_status_t;

endpackage

`default_nettype wire

// ==== logic/syscfg_regfile.sv ====
`default_nettype none

module syscfg_regfile import syscfg_bus_pkg::*; import syscfg_ctrl_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire reg_req_t             req,
    output reg_rsp_t                  rsp,
    output logic                      ready,

    output tgt_cmd_t                  cmd            [NUM_TARGETS],
    input  wire tgt_status_t          status         [NUM_TARGETS],

    input  wire logic [NUM_IRQS-1:0]  periph_irq,
    output data_t                     core_boot_addr [NUM_CORES],
    output logic      [NUM_CORES-1:0] core_irq
);

    logic                   boot;
    logic [NUM_IRQS-1:0]    irq_en [NUM_CORES];
    logic [NUM_TARGETS-1:0] busy;
    logic [NUM_TARGETS-1:0] tgt_sel;
    logic                   in_mem;
    logic                   in_core;
    addr_t                  mem_off;
    addr_t                  core_off;
    addr_t                  blk;
    addr_t                  slot;
    data_t                  wmask;
    data_t                  rd_data;
    logic                   rd_err;
    logic                   wr_ok;

    // requests wait while bootstrap runs
    assign ready = !boot;

    // busy also covers the cycle the pulse is in flight
    always_comb begin
        for (int t = 0; t < NUM_TARGETS; t++) begin
            busy[t] = (status[t].cmd != CMD_NONE) || cmd[t].valid;
        end
    end

    // split word index into block and slot
    always_comb begin
        mem_off  = req.index - MEM_BASE;
        core_off = req.index - CORE_BASE;
        in_mem   = (req.index >= MEM_BASE) && (req.index < CORE_BASE);
        in_core  = (req.index >= CORE_BASE);
        blk      = in_core ? (core_off / CORE_STRIDE) : (mem_off / MEM_STRIDE);
        slot     = in_core ? (core_off % CORE_STRIDE) : (mem_off % MEM_STRIDE);
        for (int t = 0; t < NUM_MEMS; t++) begin
            tgt_sel[t] = in_mem && (blk == addr_t'(t));
        end
        for (int c = 0; c < NUM_CORES; c++) begin
            tgt_sel[NUM_MEMS+c] = in_core && (blk == addr_t'(c));
        end
        // byte strobe to bit mask
        for (int b = 0; b < STRB_WIDTH; b++) begin
            wmask[b*8 +: 8] = {8{req.strb[b]}};
        end
    end

    // read data and error, nothing selected means error
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b1;
        for (int t = 0; t < NUM_TARGETS; t++) begin
            if (tgt_sel[t]) begin
                case (slot)
                    REG_STATUS: begin
                        rd_data = data_t'({status[t].stopped, status[t].paused});
                        rd_err  = req.write;
                    end
                    REG_COMMAND: begin
                        rd_data = data_t'(status[t].cmd);
                        rd_err  = req.write && busy[t];
                    end
                    default: rd_err = 1'b1;
                endcase
            end
        end
        // extra slots exist on cores only
        for (int c = 0; c < NUM_CORES; c++) begin
            if (tgt_sel[NUM_MEMS+c]) begin
                case (slot)
                    REG_BOOT_ADDR: begin
                        rd_data = core_boot_addr[c];
                        rd_err  = 1'b0;
                    end
                    REG_IRQ_EN: begin
                        rd_data = data_t'(irq_en[c]);
                        rd_err  = 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign wr_ok = req.valid && req.write && !rd_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot <= 1'b1;
            for (int t = 0; t < NUM_TARGETS; t++) begin
                cmd[t] <= '0;
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                core_boot_addr[c] <= BOOT_ADDR_RESET;
                irq_en[c]         <= '0;
            end
        end else begin
            for (int t = 0; t < NUM_TARGETS; t++) begin
                cmd[t].valid <= 1'b0;
            end
            if (boot) begin
                // memory 0 first, then core 0
                if (!busy[0] && !busy[NUM_MEMS]) begin
                    if (status[0].stopped) begin
                        cmd[0] <= '{valid: 1'b1, cmd: CMD_RESUME};
                    end else if (status[NUM_MEMS].stopped) begin
                        cmd[NUM_MEMS] <= '{valid: 1'b1, cmd: CMD_RESUME};
                    end else begin
                        boot <= 1'b0;
                    end
                end
            end else if (wr_ok) begin
                for (int t = 0; t < NUM_TARGETS; t++) begin
                    if (tgt_sel[t] && (slot == REG_COMMAND)) begin
                        cmd[t] <= '{valid: 1'b1, cmd: cmd_t'(req.wdata[2:0])};
                    end
                end
                for (int c = 0; c < NUM_CORES; c++) begin
                    if (tgt_sel[NUM_MEMS+c] && (slot == REG_BOOT_ADDR)) begin
                        core_boot_addr[c] <= (core_boot_addr[c] & ~wmask) | (req.wdata & wmask);
                    end
                    if (tgt_sel[NUM_MEMS+c] && (slot == REG_IRQ_EN)) begin
                        irq_en[c] <= (irq_en[c] & ~wmask[NUM_IRQS-1:0])
                                   | (req.wdata[NUM_IRQS-1:0] & wmask[NUM_IRQS-1:0]);
                    end
                end
            end
        end
    end

    // answer one cycle after the request
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp <= '{rdata: rd_data, err: rd_err};
        end
    end

    // masked or of the peripheral lines
    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            core_irq[c] = |(irq_en[c] & periph_irq);
        end
    end

    a_no_req_in_boot: assert property (@(posedge clk) disable iff (!rst_n)
        req.valid |-> ready);

endmodule

`default_nettype wire

// ==== logic/syscfg_top.sv ====
`default_nettype none

module syscfg_top import syscfg_bus_pkg::*; import syscfg_ctrl_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire addr_t                  awaddr,
    input  wire logic                   awvalid,
    output logic                        awready,
    input  wire data_t                  wdata,
    input  wire strb_t                  wstrb,
    input  wire logic                   wvalid,
    output logic                        wready,
    output resp_t                       bresp,
    output logic                        bvalid,
    input  wire logic                   bready,
    input  wire addr_t                  araddr,
    input  wire logic                   arvalid,
    output logic                        arready,
    output data_t                       rdata,
    output resp_t                       rresp,
    output logic                        rvalid,
    input  wire logic                   rready,

    output logic      [NUM_TARGETS-1:0] tgt_rst,
    output logic      [NUM_TARGETS-1:0] tgt_pause_req,
    input  wire logic [NUM_TARGETS-1:0] tgt_pause_ack,
    input  wire logic [NUM_IRQS-1:0]    periph_irq,
    output data_t                       core_boot_addr [NUM_CORES],
    output logic      [NUM_CORES-1:0]   core_irq
);

    // register access between port and register file
    reg_req_t    req;
    reg_rsp_t    rsp;
    logic        rf_ready;

    // per-target command and status
    tgt_cmd_t    tgt_cmd    [NUM_TARGETS];
    tgt_status_t tgt_status [NUM_TARGETS];

    axil_slave_port i_axil_slave_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ready   (rf_ready),
        .req     (req),
        .rsp     (rsp)
    );

    syscfg_regfile i_syscfg_regfile (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .rsp            (rsp),
        .ready          (rf_ready),
        .cmd            (tgt_cmd),
        .status         (tgt_status),
        .periph_irq     (periph_irq),
        .core_boot_addr (core_boot_addr),
        .core_irq       (core_irq)
    );

    // memories first, then cores
    for (genvar t = 0; t < NUM_TARGETS; t++) begin : g_maestro
        target_maestro i_target_maestro (
            .clk           (clk),
            .rst_n         (rst_n),
            .cmd           (tgt_cmd[t]),
            .status        (tgt_status[t]),
            .tgt_rst       (tgt_rst[t]),
            .tgt_pause_req (tgt_pause_req[t]),
            .tgt_pause_ack (tgt_pause_ack[t])
        );
    end

endmodule

`default_nettype wire

// ==== logic/target_maestro.sv ====
`default_nettype none

module target_maestro import syscfg_ctrl_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,

    input  wire tgt_cmd_t cmd,
    output tgt_status_t   status,

    output logic          tgt_rst,
    output logic          tgt_pause_req,
    input  wire logic     tgt_pause_ack
);

    cmd_t active;
    logic paused;
    logic stopped;

    assign status = '{paused: paused, stopped: stopped, cmd: active};

    // target comes up stopped and held in reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active        <= CMD_NONE;
            paused        <= 1'b0;
            stopped       <= 1'b1;
            tgt_rst       <= 1'b1;
            tgt_pause_req <= 1'b0;
        end else begin
            case (active)
                CMD_NONE: begin
                    // unknown codes never become active
                    if (cmd.valid
                        && (cmd.cmd inside {CMD_RESUME, CMD_PAUSE, CMD_STOP, CMD_RESET})) begin
                        active <= cmd.cmd;
                    end
                end
                CMD_RESUME: begin
                    tgt_rst       <= 1'b0;
                    tgt_pause_req <= 1'b0;
                    // wait for the handshake to settle low
                    if (!tgt_pause_req && !tgt_pause_ack) begin
                        active  <= CMD_NONE;
                        paused  <= 1'b0;
                        stopped <= 1'b0;
                    end
                end
                CMD_PAUSE: begin
                    tgt_pause_req <= 1'b1;
                    if (tgt_pause_req && tgt_pause_ack) begin
                        active <= CMD_NONE;
                        paused <= 1'b1;
                    end
                end
                CMD_STOP: begin
                    tgt_pause_req <= 1'b1;
                    if (tgt_pause_req && tgt_pause_ack) begin
                        tgt_rst <= 1'b1;
                        active  <= CMD_NONE;
                        stopped <= 1'b1;
                    end
                end
                CMD_RESET: begin
                    tgt_pause_req <= 1'b1;
                    // stop, then carry on as resume
                    if (tgt_pause_req && tgt_pause_ack) begin
                        tgt_rst <= 1'b1;
                        active  <= CMD_RESUME;
                        stopped <= 1'b1;
                    end
                end
                default: active <= CMD_NONE;
            endcase
        end
    end

    a_cmd_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd.valid |-> (active == CMD_NONE));

endmodule

`default_nettype wire

// ==== sim.f ====
logic/syscfg_bus_pkg.sv
logic/syscfg_ctrl_pkg.sv
logic/axil_slave_port.sv
logic/target_maestro.sv
logic/syscfg_regfile.sv
logic/syscfg_top.sv
bench/tb_clock_gen.sv
bench/tb_syscfg.sv
